/* order_return_defines.svh */
`ifndef ORDER_RETURN_DEFINES_SVH
`define ORDER_RETURN_DEFINES_SVH

// Width of one memory word.
`define ORDER_RETURN_DATA_WIDTH 16

// Address width, 16 words of storage.
`define ORDER_RETURN_ADDR_WIDTH 4

// Sequence tag width.
// Each access kind may have 2**TAG_LOG accesses outstanding.
`define ORDER_RETURN_TAG_LOG 3

// Pending slots in the memory backend.
// The issuer caps the total outstanding count at this value.
`define ORDER_RETURN_SLOTS 8

`endif

/* access_pkg.sv */
package access_pkg;

	// Kind of a host access.
	// Reads and writes carry separate tag sequences.
	typedef enum logic {
		access_read  = 1'b0,
		access_write = 1'b1
	} access_kind_t;

endpackage

/* completion_pkg.sv */
package completion_pkg;

	// Occupancy of one backend slot.
	typedef enum logic {
		slot_free    = 1'b0,
		slot_waiting = 1'b1
	} slot_state_t;

endpackage

/* request_issuer.sv */
`timescale 1ns/100ps
`include "order_return_defines.svh"

module request_issuer (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 req_strobe,
	input  access_pkg::access_kind_t             req_kind,
	input  logic [`ORDER_RETURN_ADDR_WIDTH-1:0]  req_addr,
	input  logic [`ORDER_RETURN_DATA_WIDTH-1:0]  req_wdata,
	input  logic                                 read_done,
	input  logic                                 write_done,
	output logic                                 busy,
	output logic                                 issue_strobe,
	output access_pkg::access_kind_t             issue_kind,
	output logic [`ORDER_RETURN_ADDR_WIDTH-1:0]  issue_addr,
	output logic [`ORDER_RETURN_DATA_WIDTH-1:0]  issue_wdata,
	output logic [`ORDER_RETURN_TAG_LOG-1:0]     issue_tag
);
	import access_pkg::*;

	localparam int KIND_W  = `ORDER_RETURN_TAG_LOG + 1;
	localparam int TOTAL_W = $clog2(`ORDER_RETURN_SLOTS + 1);
	localparam int WINDOW  = 1 << `ORDER_RETURN_TAG_LOG;

	logic [`ORDER_RETURN_TAG_LOG-1:0] next_read_tag;
	logic [`ORDER_RETURN_TAG_LOG-1:0] next_write_tag;
	logic [KIND_W-1:0]                read_out;
	logic [KIND_W-1:0]                write_out;
	logic [TOTAL_W-1:0]               total_out;
	logic                             accept;
	logic                             accept_read;
	logic                             accept_write;

	// Full tag window of either kind, or every backend slot in use.
	assign busy = (read_out == KIND_W'(WINDOW)) ||
		(write_out == KIND_W'(WINDOW)) ||
		(total_out == TOTAL_W'(`ORDER_RETURN_SLOTS));

	assign accept       = req_strobe && !busy;
	assign accept_read  = accept && (req_kind == access_read);
	assign accept_write = accept && (req_kind == access_write);

	always_ff @(posedge clk) begin
		if (rst_n) begin
			next_read_tag  <= '0;
			next_write_tag <= '0;
			read_out       <= '0;
			write_out      <= '0;
			total_out      <= '0;
			issue_strobe   <= 1'b0;
		end else begin
			issue_strobe <= accept;
			if (accept_read) begin
				next_read_tag <= next_read_tag + 1'b1;
			end
			if (accept_write) begin
				next_write_tag <= next_write_tag + 1'b1;
			end
			// An access stays outstanding until its in-order done pulse.
			read_out  <= read_out + KIND_W'(accept_read) - KIND_W'(read_done);
			write_out <= write_out + KIND_W'(accept_write) - KIND_W'(write_done);
			total_out <= total_out + TOTAL_W'(accept) - TOTAL_W'(read_done)
				- TOTAL_W'(write_done);
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			issue_kind  <= req_kind;
			issue_addr  <= req_addr;
			issue_wdata <= req_wdata;
			issue_tag   <= (req_kind == access_read) ? next_read_tag : next_write_tag;
		end
	end

endmodule

/* ooo_memory.sv */
`timescale 1ns/100ps
`include "order_return_defines.svh"

module ooo_memory (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 issue_strobe,
	input  access_pkg::access_kind_t             issue_kind,
	input  logic [`ORDER_RETURN_ADDR_WIDTH-1:0]  issue_addr,
	input  logic [`ORDER_RETURN_DATA_WIDTH-1:0]  issue_wdata,
	input  logic [`ORDER_RETURN_TAG_LOG-1:0]     issue_tag,
	output logic                                 resp_valid,
	output access_pkg::access_kind_t             resp_kind,
	output logic [`ORDER_RETURN_TAG_LOG-1:0]     resp_tag,
	output logic [`ORDER_RETURN_DATA_WIDTH-1:0]  resp_data
);
	import access_pkg::*;
	import completion_pkg::*;

	localparam int SLOTS  = `ORDER_RETURN_SLOTS;
	localparam int SLOT_W = $clog2(SLOTS);
	localparam int WORDS  = 1 << `ORDER_RETURN_ADDR_WIDTH;

	logic [`ORDER_RETURN_DATA_WIDTH-1:0] mem [0:WORDS-1];

	slot_state_t                         slot_state [0:SLOTS-1];
	access_kind_t                        slot_kind  [0:SLOTS-1];
	logic [`ORDER_RETURN_TAG_LOG-1:0]    slot_tag   [0:SLOTS-1];
	logic [`ORDER_RETURN_DATA_WIDTH-1:0] slot_data  [0:SLOTS-1];
	logic [2:0]                          slot_count [0:SLOTS-1];

	logic [7:0]        lfsr;
	logic [SLOT_W-1:0] free_slot;
	logic [SLOT_W-1:0] ready_slot;
	logic              ready_found;

	// Lowest free slot and lowest expired slot.
	always_comb begin
		free_slot   = '0;
		ready_slot  = '0;
		ready_found = 1'b0;
		for (int i = SLOTS - 1; i >= 0; i--) begin
			if (slot_state[i] == slot_free) begin
				free_slot = SLOT_W'(i);
			end
			if (slot_state[i] == slot_waiting && slot_count[i] == 3'd0) begin
				ready_slot  = SLOT_W'(i);
				ready_found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < SLOTS; i++) begin
				slot_state[i] <= slot_free;
			end
			resp_valid <= 1'b0;
			lfsr       <= 8'ha5;
		end else begin
			// x^8 + x^6 + x^5 + x^4 + 1.
			lfsr       <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
			resp_valid <= ready_found;
			if (ready_found) begin
				slot_state[ready_slot] <= slot_free;
			end
			if (issue_strobe) begin
				slot_state[free_slot] <= slot_waiting;
			end
		end
	end

	// Countdown of 0 to 7 gives 2 to 9 cycles from issue to response.
	always_ff @(posedge clk) begin
		for (int i = 0; i < SLOTS; i++) begin
			if (slot_state[i] == slot_waiting && slot_count[i] != 3'd0) begin
				slot_count[i] <= slot_count[i] - 3'd1;
			end
		end
		if (issue_strobe) begin
			slot_count[free_slot] <= lfsr[2:0];
			slot_kind[free_slot]  <= issue_kind;
			slot_tag[free_slot]   <= issue_tag;
			// Read data is fixed here, in issue order.
			slot_data[free_slot]  <= (issue_kind == access_read) ? mem[issue_addr] : issue_wdata;
		end
		if (ready_found) begin
			resp_kind <= slot_kind[ready_slot];
			resp_tag  <= slot_tag[ready_slot];
			resp_data <= slot_data[ready_slot];
		end
	end

	always_ff @(posedge clk) begin
		if (issue_strobe && issue_kind == access_write) begin
			mem[issue_addr] <= issue_wdata;
		end
	end

endmodule

/* returner.sv */
`timescale 1ns/100ps
`include "order_return_defines.svh"

module returner (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 valid,
	input  access_pkg::access_kind_t             the_type,
	input  logic [`ORDER_RETURN_DATA_WIDTH-1:0]  data_in,
	input  logic [`ORDER_RETURN_TAG_LOG-1:0]     index,
	output logic                                 write_done,
	output logic                                 read_done,
	output logic [`ORDER_RETURN_DATA_WIDTH-1:0]  data_out
);
	import access_pkg::*;

	localparam int ENTRIES = 1 << `ORDER_RETURN_TAG_LOG;

	logic [`ORDER_RETURN_TAG_LOG-1:0] read_counter;
	logic [`ORDER_RETURN_TAG_LOG-1:0] write_counter;

	// Parked responses, one entry per tag.
	logic [`ORDER_RETURN_DATA_WIDTH-1:0] read_store [0:ENTRIES-1];
	logic [ENTRIES-1:0]                  read_parked;
	logic [ENTRIES-1:0]                  write_parked;

	logic read_in;
	logic write_in;
	logic read_hit;
	logic write_hit;

	assign read_in   = valid && (the_type == access_read);
	assign write_in  = valid && (the_type == access_write);
	assign read_hit  = read_in && (index == read_counter);
	assign write_hit = write_in && (index == write_counter);

	always_ff @(posedge clk) begin
		if (rst_n) begin
			read_counter  <= '0;
			write_counter <= '0;
			read_parked   <= '0;
			write_parked  <= '0;
			read_done     <= 1'b0;
			write_done    <= 1'b0;
			data_out      <= '0;
		end else begin
			read_done  <= 1'b0;
			write_done <= 1'b0;
			data_out   <= '0;

			// An incoming hit and a parked expected entry never coincide.
			if (read_hit) begin
				read_done    <= 1'b1;
				data_out     <= data_in;
				read_counter <= read_counter + 1'b1;
			end else if (read_parked[read_counter]) begin
				read_done                 <= 1'b1;
				data_out                  <= read_store[read_counter];
				read_parked[read_counter] <= 1'b0;
				read_counter              <= read_counter + 1'b1;
			end
			if (read_in && !read_hit) begin
				read_parked[index] <= 1'b1;
			end

			if (write_hit) begin
				write_done    <= 1'b1;
				write_counter <= write_counter + 1'b1;
			end else if (write_parked[write_counter]) begin
				write_done                  <= 1'b1;
				write_parked[write_counter] <= 1'b0;
				write_counter               <= write_counter + 1'b1;
			end
			if (write_in && !write_hit) begin
				write_parked[index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (read_in && !read_hit) begin
			read_store[index] <= data_in;
		end
	end

endmodule

/* order_return_top.sv */
`timescale 1ns/100ps
`include "order_return_defines.svh"

module order_return_top (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 req_strobe,
	input  access_pkg::access_kind_t             req_kind,
	input  logic [`ORDER_RETURN_ADDR_WIDTH-1:0]  req_addr,
	input  logic [`ORDER_RETURN_DATA_WIDTH-1:0]  req_wdata,
	output logic                                 busy,
	output logic                                 read_done,
	output logic                                 write_done,
	output logic [`ORDER_RETURN_DATA_WIDTH-1:0]  data_out
);
	import access_pkg::*;

	logic                                issue_strobe;
	access_kind_t                        issue_kind;
	logic [`ORDER_RETURN_ADDR_WIDTH-1:0] issue_addr;
	logic [`ORDER_RETURN_DATA_WIDTH-1:0] issue_wdata;
	logic [`ORDER_RETURN_TAG_LOG-1:0]    issue_tag;

	logic                                resp_valid;
	access_kind_t                        resp_kind;
	logic [`ORDER_RETURN_TAG_LOG-1:0]    resp_tag;
	logic [`ORDER_RETURN_DATA_WIDTH-1:0] resp_data;

	// Done pulses also retire the issuer's outstanding counts.
	request_issuer issuer0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_strobe   (req_strobe),
		.req_kind     (req_kind),
		.req_addr     (req_addr),
		.req_wdata    (req_wdata),
		.read_done    (read_done),
		.write_done   (write_done),
		.busy         (busy),
		.issue_strobe (issue_strobe),
		.issue_kind   (issue_kind),
		.issue_addr   (issue_addr),
		.issue_wdata  (issue_wdata),
		.issue_tag    (issue_tag)
	);

	ooo_memory memory0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue_strobe (issue_strobe),
		.issue_kind   (issue_kind),
		.issue_addr   (issue_addr),
		.issue_wdata  (issue_wdata),
		.issue_tag    (issue_tag),
		.resp_valid   (resp_valid),
		.resp_kind    (resp_kind),
		.resp_tag     (resp_tag),
		.resp_data    (resp_data)
	);

	returner returner0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.valid      (resp_valid),
		.the_type   (resp_kind),
		.data_in    (resp_data),
		.index      (resp_tag),
		.write_done (write_done),
		.read_done  (read_done),
		.data_out   (data_out)
	);

endmodule

/* tb_order_return_model.svh */
`ifndef TB_ORDER_RETURN_MODEL_SVH
`define TB_ORDER_RETURN_MODEL_SVH

// Shadow of the backend storage, written in issue order.
logic [`ORDER_RETURN_DATA_WIDTH-1:0] shadow_mem [0:(1 << `ORDER_RETURN_ADDR_WIDTH)-1];

// Read data still owed to the host, oldest first.
logic [`ORDER_RETURN_DATA_WIDTH-1:0] expected_reads [$];

// Outstanding accesses as the issuer should count them in the current cycle.
int out_read;
int out_write;
int out_total;
int pending_writes;

function automatic void clear_model();
	expected_reads.delete();
	out_read       = 0;
	out_write      = 0;
	out_total      = 0;
	pending_writes = 0;
endfunction

function automatic bit window_full();
	return (out_read >= (1 << `ORDER_RETURN_TAG_LOG)) ||
		(out_write >= (1 << `ORDER_RETURN_TAG_LOG)) ||
		(out_total >= `ORDER_RETURN_SLOTS);
endfunction

function automatic void record_issue(input access_kind_t kind,
	input logic [`ORDER_RETURN_ADDR_WIDTH-1:0] addr,
	input logic [`ORDER_RETURN_DATA_WIDTH-1:0] wdata);
	if (kind == access_write) begin
		shadow_mem[addr] = wdata;
		out_write++;
		pending_writes++;
	end else begin
		expected_reads.push_back(shadow_mem[addr]);
		out_read++;
	end
	out_total++;
endfunction

function automatic void retire_done(input logic rd, input logic wr);
	if (rd === 1'b1) begin
		out_read--;
		out_total--;
	end
	if (wr === 1'b1) begin
		out_write--;
		out_total--;
	end
endfunction

`endif

/* tb_order_return.sv */
`timescale 1ns/100ps
`include "order_return_defines.svh"

module tb_order_return;
	import access_pkg::*;
	import completion_pkg::*;

	localparam int AW             = `ORDER_RETURN_ADDR_WIDTH;
	localparam int DW             = `ORDER_RETURN_DATA_WIDTH;
	localparam int WORDS          = 1 << AW;
	localparam int WINDOW         = 1 << `ORDER_RETURN_TAG_LOG;
	localparam int FILL_WRITES    = 50;
	localparam int MIXED_COUNT    = 400;
	localparam int BURST_COUNT    = 100;
	localparam int TOTAL_REQUESTS = FILL_WRITES + WORDS + MIXED_COUNT + BURST_COUNT;
	localparam int CYCLE_LIMIT    = TOTAL_REQUESTS * 12 + 200;

	logic          clk;
	logic          rst_n;
	logic          req_strobe;
	access_kind_t  req_kind;
	logic [AW-1:0] req_addr;
	logic [DW-1:0] req_wdata;
	logic          busy;
	logic          read_done;
	logic          write_done;
	logic [DW-1:0] data_out;

	integer        seed;
	int            cycle_count;
	int            error_count;
	int            zero_errors;
	int            tests_run;
	int            tests_failed;
	int            reads_seen;
	int            writes_seen;
	int            busy_high_cycles;
	int            waiting_slots;
	logic [DW-1:0] expected_data;
	bit            can_issue;
	bit            monitor_on;

	`include "tb_order_return_model.svh"

	order_return_top dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_strobe (req_strobe),
		.req_kind   (req_kind),
		.req_addr   (req_addr),
		.req_wdata  (req_wdata),
		.busy       (busy),
		.read_done  (read_done),
		.write_done (write_done),
		.data_out   (data_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the accesses did not all complete within %0d cycles", CYCLE_LIMIT);
		$display("TB FAILED");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [DW-1:0] expected,
		input logic [DW-1:0] actual);
		$display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		error_count++;
	endtask

	task automatic report_problem(input string text);
		$display("at %0t: %s", $time, text);
		error_count++;
	endtask

	task automatic report_test(input string name, input int errors);
		tests_run++;
		if (errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors);
		end
	endtask

	// Outputs are stable at the falling edge; the model advances one cycle here.
	always @(negedge clk) begin
		if (monitor_on) begin
			if (busy !== window_full()) begin
				report_mismatch("busy", DW'(window_full()), DW'(busy));
			end
			if (busy === 1'b1) begin
				busy_high_cycles++;
			end
			waiting_slots = 0;
			for (int i = 0; i < `ORDER_RETURN_SLOTS; i++) begin
				if (dut0.memory0.slot_state[i] == slot_waiting) begin
					waiting_slots++;
				end
			end
			if (waiting_slots > out_total) begin
				report_problem("backend holds more slots than accesses outstanding");
			end
			if (read_done === 1'b1) begin
				reads_seen++;
				if (expected_reads.size() == 0) begin
					report_problem("read_done pulsed with no read outstanding");
				end else begin
					expected_data = expected_reads.pop_front();
					if (data_out !== expected_data) begin
						report_mismatch("data_out", expected_data, data_out);
					end
				end
			end else if (data_out !== '0) begin
				zero_errors++;
				report_mismatch("data_out", '0, data_out);
			end
			if (write_done === 1'b1) begin
				writes_seen++;
				if (pending_writes == 0) begin
					report_problem("write_done pulsed with no write outstanding");
				end else begin
					pending_writes--;
				end
			end
			// A strobe counts only in a cycle where busy is low.
			if (req_strobe === 1'b1 && busy === 1'b0) begin
				record_issue(req_kind, req_addr, req_wdata);
			end
			retire_done(read_done, write_done);
			if (out_read > WINDOW || out_write > WINDOW || out_total > `ORDER_RETURN_SLOTS) begin
				report_problem("outstanding accesses went past the limit");
			end
			// Prediction of busy for the cycle after the next rising edge.
			can_issue = !window_full();
		end
	end

	task automatic send_access(input access_kind_t kind, input logic [AW-1:0] addr,
		input logic [DW-1:0] wdata);
		bit sent;
		sent = 1'b0;
		while (!sent) begin
			@(posedge clk);
			if (can_issue) begin
				req_strobe <= 1'b1;
				req_kind   <= kind;
				req_addr   <= addr;
				req_wdata  <= wdata;
				sent = 1'b1;
			end else begin
				req_strobe <= 1'b0;
			end
		end
	endtask

	// Keeps strobing the same access until the issuer takes it.
	task automatic hold_access(input access_kind_t kind, input logic [AW-1:0] addr,
		input logic [DW-1:0] wdata);
		bit taken;
		taken = 1'b0;
		while (!taken) begin
			@(posedge clk);
			req_strobe <= 1'b1;
			req_kind   <= kind;
			req_addr   <= addr;
			req_wdata  <= wdata;
			@(negedge clk);
			taken = (busy === 1'b0);
		end
	endtask

	task automatic wait_drain();
		@(posedge clk);
		req_strobe <= 1'b0;
		while (out_total != 0) begin
			@(posedge clk);
		end
	endtask

	initial begin
		int           mark;
		int           writes_issued;
		int           writes_before;
		int           busy_before;
		logic [31:0]  rnd;
		access_kind_t kind;

		seed             = 41012;
		error_count      = 0;
		zero_errors      = 0;
		tests_run        = 0;
		tests_failed     = 0;
		reads_seen       = 0;
		writes_seen      = 0;
		busy_high_cycles = 0;
		monitor_on       = 1'b0;
		can_issue        = 1'b0;
		clear_model();
		rst_n      = 1'b1;
		req_strobe = 1'b0;
		req_kind   = access_read;
		req_addr   = '0;
		req_wdata  = '0;

		repeat (4) @(posedge clk);
		rst_n <= 1'b0;
		monitor_on = 1'b1;
		can_issue  = 1'b1;

		mark = error_count;
		@(negedge clk);
		if (busy !== 1'b0) report_mismatch("busy", '0, DW'(busy));
		if (read_done !== 1'b0) report_mismatch("read_done", '0, DW'(read_done));
		if (write_done !== 1'b0) report_mismatch("write_done", '0, DW'(write_done));
		if (data_out !== '0) report_mismatch("data_out", '0, data_out);
		report_test("reset values", error_count - mark);

		mark = error_count;
		for (int i = 0; i < FILL_WRITES; i++) begin
			// The first pass writes every address once.
			send_access(access_write, (i < WORDS) ? AW'(i) : AW'($random(seed)),
				DW'($random(seed)));
		end
		for (int i = 0; i < WORDS; i++) begin
			send_access(access_read, AW'(i), '0);
		end
		wait_drain();
		report_test("write then read", error_count - mark);

		mark = error_count;
		writes_issued = 0;
		writes_before = writes_seen;
		for (int i = 0; i < MIXED_COUNT; i++) begin
			rnd  = $random(seed);
			kind = rnd[0] ? access_write : access_read;
			if (kind == access_write) writes_issued++;
			send_access(kind, rnd[AW+3:4], DW'($random(seed)));
		end
		wait_drain();
		if (writes_seen - writes_before != writes_issued) begin
			report_problem($sformatf("%0d writes issued but %0d write_done pulses seen",
				writes_issued, writes_seen - writes_before));
		end
		report_test("mixed traffic", error_count - mark);

		mark = error_count;
		busy_before = busy_high_cycles;
		for (int i = 0; i < BURST_COUNT; i++) begin
			rnd  = $random(seed);
			kind = rnd[1] ? access_write : access_read;
			hold_access(kind, rnd[AW+3:4], DW'($random(seed)));
		end
		wait_drain();
		if (busy_high_cycles == busy_before) begin
			report_problem("busy never rose during the back-to-back burst");
		end
		report_test("back-pressure", error_count - mark);

		report_test("data_out zero without read_done", zero_errors);

		mark = error_count;
		wait_drain();
		if (expected_reads.size() != 0) report_problem("reads still expected after drain");
		if (pending_writes != 0) report_problem("writes still pending after drain");
		@(negedge clk);
		if (busy !== 1'b0) report_mismatch("busy", '0, DW'(busy));
		for (int i = 0; i < `ORDER_RETURN_SLOTS; i++) begin
			if (dut0.memory0.slot_state[i] != slot_free) begin
				report_problem("backend slot still waiting after drain");
			end
		end
		report_test("drain", error_count - mark);

		$display("summary: %0d tests, %0d failed, %0d errors, %0d reads and %0d writes done",
			tests_run, tests_failed, error_count, reads_seen, writes_seen);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* order_return.f */
+incdir+.
access_pkg.sv
completion_pkg.sv
request_issuer.sv
ooo_memory.sv
returner.sv
order_return_top.sv
tb_order_return.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_order_return
FILELIST  := order_return.f
VFLAGS    := --binary --timing --timescale 1ns/100ps -Wno-fatal
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
HEADERS   := order_return_defines.svh tb_order_return_model.svh
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(HEADERS)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
